/* hw/ecc_mem_defs.svh */
`ifndef ECC_MEM_DEFS_SVH
`define ECC_MEM_DEFS_SVH

// user data bits in one word
`define ECC_DATA_WIDTH  41
`define ECC_CHECK_WIDTH 7

// stored word is data plus check bits
`define ECC_CODE_WIDTH  48

// 64 words in the scratchpad
`define ECC_ADDR_WIDTH  6
`define ECC_COUNT_WIDTH 8

`endif

/* hw/ecc_mem_pkg.sv */
`include "ecc_mem_defs.svh"

package ecc_mem_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]  data_word_t;
    typedef logic [`ECC_CHECK_WIDTH-1:0] check_bits_t;

    // check bits sit above the data in the stored word
    typedef logic [`ECC_CODE_WIDTH-1:0]  codeword_t;
    typedef logic [`ECC_ADDR_WIDTH-1:0]  mem_addr_t;
    typedef logic [`ECC_COUNT_WIDTH-1:0] err_count_t;

    // seven even-parity equations of the 41-bit SECDED code
    function automatic check_bits_t ecc_check_bits(input data_word_t d);
        check_bits_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38] ^ d[40];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36] ^ d[39] ^ d[40];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40];
        // the next three cover contiguous runs of data bits
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]);
        p[4] = ^d[25:11];
        p[5] = ^d[40:26];
        // overall bit that separates single from double errors
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38] ^ d[39];
        return p;
    endfunction

endpackage

/* hw/ecc_write_port.sv */
`timescale 1ns/1ns

module ecc_write_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  ecc_mem_pkg::mem_addr_t  wr_addr,
    input  ecc_mem_pkg::data_word_t wr_data,
    input  ecc_mem_pkg::codeword_t  inj_mask,
    output logic                    store_en,
    output ecc_mem_pkg::mem_addr_t  store_addr,
    output ecc_mem_pkg::codeword_t  store_code
);

    import ecc_mem_pkg::*;

    codeword_t clean_code;
    codeword_t faulty_code;

    // check bits go on top of the data word
    assign clean_code = {ecc_check_bits(wr_data), wr_data};

    // diagnostic flips may land on data bits and check bits of the stored word
    assign faulty_code = clean_code ^ inj_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            store_en <= 1'b0;
        end else begin
            store_en <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            store_addr <= wr_addr;
            store_code <= faulty_code;
        end
    end

endmodule

/* hw/ecc_storage.sv */
`timescale 1ns/1ns

`include "ecc_mem_defs.svh"

module ecc_storage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   store_en,
    input  ecc_mem_pkg::mem_addr_t store_addr,
    input  ecc_mem_pkg::codeword_t store_code,
    input  logic                   rd_en,
    input  ecc_mem_pkg::mem_addr_t rd_addr,
    output logic                   fetch_valid,
    output ecc_mem_pkg::codeword_t fetch_code
);

    import ecc_mem_pkg::*;

    localparam int DEPTH = 1 << `ECC_ADDR_WIDTH;

    codeword_t mem [0:DEPTH-1];

    // a read in the same cycle as a store sees the old word
    always_ff @(posedge clk) begin
        if (store_en) begin
            mem[store_addr] <= store_code;
        end
        if (rd_en) begin
            fetch_code <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= rd_en;
        end
    end

endmodule

/* hw/ecc_41_codec.sv */
`timescale 1ns/1ns

`include "ecc_mem_defs.svh"

module ecc_41_codec (
    input  ecc_mem_pkg::codeword_t  code_in,
    input  logic                    bypass,
    output ecc_mem_pkg::data_word_t data_out,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    import ecc_mem_pkg::*;

    data_word_t  stored_data;
    check_bits_t stored_check;
    check_bits_t syndrome;
    logic [5:0]  flip_idx;
    logic        flip_hit;
    logic        single_err;
    logic        double_err;
    data_word_t  fix_mask;

    assign stored_data  = code_in[`ECC_DATA_WIDTH-1:0];
    assign stored_check = code_in[`ECC_CODE_WIDTH-1:`ECC_DATA_WIDTH];
    assign syndrome     = stored_check ^ ecc_check_bits(stored_data);

    // each data bit owns one syndrome column of weight three or more
    always_comb begin
        flip_hit = 1'b1;
        flip_idx = 6'd0;
        case (syndrome)
            7'b1000011: flip_idx = 6'd0;
            7'b1000101: flip_idx = 6'd1;
            7'b1000110: flip_idx = 6'd2;
            7'b0000111: flip_idx = 6'd3;
            7'b1001001: flip_idx = 6'd4;
            7'b1001010: flip_idx = 6'd5;
            7'b0001011: flip_idx = 6'd6;
            7'b1001100: flip_idx = 6'd7;
            7'b0001101: flip_idx = 6'd8;
            7'b0001110: flip_idx = 6'd9;
            7'b1001111: flip_idx = 6'd10;
            7'b1010001: flip_idx = 6'd11;
            7'b1010010: flip_idx = 6'd12;
            7'b0010011: flip_idx = 6'd13;
            7'b1010100: flip_idx = 6'd14;
            7'b0010101: flip_idx = 6'd15;
            7'b0010110: flip_idx = 6'd16;
            7'b1010111: flip_idx = 6'd17;
            7'b1011000: flip_idx = 6'd18;
            7'b0011001: flip_idx = 6'd19;
            7'b0011010: flip_idx = 6'd20;
            7'b1011011: flip_idx = 6'd21;
            7'b0011100: flip_idx = 6'd22;
            7'b1011101: flip_idx = 6'd23;
            7'b1011110: flip_idx = 6'd24;
            7'b0011111: flip_idx = 6'd25;
            7'b1100001: flip_idx = 6'd26;
            7'b1100010: flip_idx = 6'd27;
            7'b0100011: flip_idx = 6'd28;
            7'b1100100: flip_idx = 6'd29;
            7'b0100101: flip_idx = 6'd30;
            7'b0100110: flip_idx = 6'd31;
            7'b1100111: flip_idx = 6'd32;
            7'b1101000: flip_idx = 6'd33;
            7'b0101001: flip_idx = 6'd34;
            7'b0101010: flip_idx = 6'd35;
            7'b1101011: flip_idx = 6'd36;
            7'b0101100: flip_idx = 6'd37;
            7'b1101101: flip_idx = 6'd38;
            7'b1101110: flip_idx = 6'd39;
            7'b0101111: flip_idx = 6'd40;
            default:    flip_hit = 1'b0;
        endcase
    end

    // a lone syndrome bit means the flip hit a check bit and left the data intact
    always_comb begin
        single_err = flip_hit || $onehot(syndrome);
        double_err = !single_err && (syndrome != '0);
    end

    assign fix_mask = flip_hit ? (data_word_t'(1) << flip_idx) : '0;

    assign data_out = bypass ? stored_data : (stored_data ^ fix_mask);
    assign sbit_err = !bypass && single_err;
    assign dbit_err = !bypass && double_err;

endmodule

/* hw/ecc_read_port.sv */
`timescale 1ns/1ns

module ecc_read_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_valid,
    input  ecc_mem_pkg::codeword_t  fetch_code,
    input  logic                    bypass,
    input  logic                    cnt_clr,
    output logic                    rd_valid,
    output ecc_mem_pkg::data_word_t rd_data,
    output logic                    sbit_err,
    output logic                    dbit_err,
    output ecc_mem_pkg::err_count_t sbit_count,
    output ecc_mem_pkg::err_count_t dbit_count
);

    import ecc_mem_pkg::*;

    data_word_t fix_data;
    logic       fix_sbit;
    logic       fix_dbit;

    // holds at all ones instead of wrapping
    function automatic err_count_t sat_inc(input err_count_t c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

    ecc_41_codec u_codec (
        .code_in  (fetch_code),
        .bypass   (bypass),
        .data_out (fix_data),
        .sbit_err (fix_sbit),
        .dbit_err (fix_dbit)
    );

    // flags only rise together with rd_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            rd_valid <= fetch_valid;
            sbit_err <= fetch_valid && fix_sbit;
            dbit_err <= fetch_valid && fix_dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            rd_data <= fix_data;
        end
    end

    // a clear request beats a same-cycle increment
    always_ff @(posedge clk) begin
        if (!rst_n || cnt_clr) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else begin
            if (fetch_valid && fix_sbit) begin
                sbit_count <= sat_inc(sbit_count);
            end
            if (fetch_valid && fix_dbit) begin
                dbit_count <= sat_inc(dbit_count);
            end
        end
    end

endmodule

/* hw/ecc_mem_top.sv */
`timescale 1ns/1ns

module ecc_mem_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  ecc_mem_pkg::mem_addr_t  wr_addr,
    input  ecc_mem_pkg::data_word_t wr_data,
    input  ecc_mem_pkg::codeword_t  inj_mask,
    input  logic                    rd_en,
    input  ecc_mem_pkg::mem_addr_t  rd_addr,
    input  logic                    bypass,
    input  logic                    cnt_clr,
    output logic                    rd_valid,
    output ecc_mem_pkg::data_word_t rd_data,
    output logic                    sbit_err,
    output logic                    dbit_err,
    output ecc_mem_pkg::err_count_t sbit_count,
    output ecc_mem_pkg::err_count_t dbit_count
);

    import ecc_mem_pkg::*;

    logic      store_en;
    mem_addr_t store_addr;
    codeword_t store_code;
    logic      fetch_valid;
    codeword_t fetch_code;

    ecc_write_port u_write_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .inj_mask   (inj_mask),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_code (store_code)
    );

    ecc_storage u_storage (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_en    (store_en),
        .store_addr  (store_addr),
        .store_code  (store_code),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .fetch_valid (fetch_valid),
        .fetch_code  (fetch_code)
    );

    // bypass acts on the word fetched in the previous cycle
    ecc_read_port u_read_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_code  (fetch_code),
        .bypass      (bypass),
        .cnt_clr     (cnt_clr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count)
    );

endmodule

/* testbench/ecc_mem_checker.sv */
`timescale 1ns/1ns

module ecc_mem_checker (
    input logic clk,
    input logic rst_n,
    input logic rd_en,
    input logic bypass,
    input logic rd_valid,
    input logic sbit_err,
    input logic dbit_err
);

    int latency_fails = 0;
    int overlap_fails = 0;
    int stray_fails = 0;
    int bypass_fails = 0;

    // every read strobe comes back exactly two cycles later
    rd_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2))
        else begin
            $error("rd_valid does not follow rd_en by two cycles");
            latency_fails++;
        end

    flag_overlap_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(sbit_err && dbit_err))
        else begin
            $error("sbit_err and dbit_err are high together");
            overlap_fails++;
        end

    flag_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        (sbit_err || dbit_err) |-> rd_valid)
        else begin
            $error("error flag raised without rd_valid");
            stray_fails++;
        end

    // the read port samples bypass one cycle before the result
    bypass_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
        $past(bypass) |-> !(sbit_err || dbit_err))
        else begin
            $error("error flag raised on a bypassed read");
            bypass_fails++;
        end

endmodule

bind ecc_mem_top ecc_mem_checker mem_checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .bypass   (bypass),
    .rd_valid (rd_valid),
    .sbit_err (sbit_err),
    .dbit_err (dbit_err)
);

/* testbench/tb_ecc_mem.sv */
`timescale 1ns/1ns

`include "ecc_mem_defs.svh"

module tb_ecc_mem;

    import ecc_mem_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    mem_addr_t  wr_addr;
    data_word_t wr_data;
    codeword_t  inj_mask;
    logic       rd_en;
    mem_addr_t  rd_addr;
    logic       bypass;
    logic       cnt_clr;
    logic       rd_valid;
    data_word_t rd_data;
    logic       sbit_err;
    logic       dbit_err;
    err_count_t sbit_count;
    err_count_t dbit_count;

    integer seed = 37250;
    int data_errors = 0;
    int flag_errors = 0;
    int count_errors = 0;
    int other_errors = 0;

    // one entry per case with the same index in every column
    string     row_name[$];
    mem_addr_t row_addr[$];
    codeword_t row_mask[$];
    logic      row_bypass[$];
    logic      row_sbit[$];
    logic      row_dbit[$];

    check_bits_t col_table [0:`ECC_DATA_WIDTH-1];
    err_count_t  exp_sbit_count;
    err_count_t  exp_dbit_count;

    ecc_mem_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .inj_mask   (inj_mask),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .bypass     (bypass),
        .cnt_clr    (cnt_clr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) wait_cycle();
    endtask

    function automatic data_word_t rand_word();
        return data_word_t'({$random(seed), $random(seed)});
    endfunction

    // columns have odd weight and their low six bits count up and skip every power of two
    task automatic build_columns();
        int v;
        int idx;
        logic [5:0] low;
        v = 3;
        idx = 0;
        while (idx < `ECC_DATA_WIDTH) begin
            if ((v & (v - 1)) != 0) begin
                low = v[5:0];
                col_table[idx] = {~(^low), low};
                idx++;
            end
            v++;
        end
    endtask

    task automatic add_row(input string name, input mem_addr_t addr, input codeword_t mask,
                           input logic byp, input logic s, input logic d);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_mask.push_back(mask);
        row_bypass.push_back(byp);
        row_sbit.push_back(s);
        row_dbit.push_back(d);
    endtask

    task automatic build_table();
        add_row("clean_a0", 6'd0, '0, 1'b0, 1'b0, 1'b0);
        add_row("clean_a21", 6'd21, '0, 1'b0, 1'b0, 1'b0);
        add_row("clean_a42", 6'd42, '0, 1'b0, 1'b0, 1'b0);
        add_row("clean_a63", 6'd63, '0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < `ECC_CODE_WIDTH; i++) begin
            add_row($sformatf("flip_bit%0d", i), mem_addr_t'(i), codeword_t'(1) << i,
                    1'b0, 1'b1, 1'b0);
        end
        add_row("double_d3_d17", 6'd48, (codeword_t'(1) << 3) | (codeword_t'(1) << 17),
                1'b0, 1'b0, 1'b1);
        add_row("double_d0_c44", 6'd49, (codeword_t'(1) << 0) | (codeword_t'(1) << 44),
                1'b0, 1'b0, 1'b1);
        add_row("double_c41_c47", 6'd50, (codeword_t'(1) << 41) | (codeword_t'(1) << 47),
                1'b0, 1'b0, 1'b1);
        add_row("bypass_d9", 6'd52, codeword_t'(1) << 9, 1'b1, 1'b0, 1'b0);
        add_row("bypass_c45", 6'd53, codeword_t'(1) << 45, 1'b1, 1'b0, 1'b0);
        add_row("bypass_clean", 6'd54, '0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic model_read(input data_word_t d, input codeword_t m, input logic byp,
                              output data_word_t exp_data, output logic exp_s,
                              output logic exp_d);
        codeword_t   stored;
        data_word_t  sd;
        check_bits_t syn;
        logic        hit;
        stored   = {ecc_check_bits(d), d} ^ m;
        sd       = stored[`ECC_DATA_WIDTH-1:0];
        syn      = stored[`ECC_CODE_WIDTH-1:`ECC_DATA_WIDTH] ^ ecc_check_bits(sd);
        exp_data = sd;
        exp_s    = 1'b0;
        exp_d    = 1'b0;
        hit      = 1'b0;
        if (!byp && syn != '0) begin
            for (int j = 0; j < `ECC_DATA_WIDTH; j++) begin
                if (syn == col_table[j]) begin
                    exp_data = sd ^ (data_word_t'(1) << j);
                    hit = 1'b1;
                end
            end
            if (hit || $countones(syn) == 1) begin
                exp_s = 1'b1;
            end else begin
                exp_d = 1'b1;
            end
        end
    endtask

    function automatic err_count_t bump_count(input err_count_t c);
        if (c == '1) begin
            return c;
        end
        return c + err_count_t'(1);
    endfunction

    task automatic check_data(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            data_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input err_count_t expected,
                               input err_count_t actual);
        if (actual !== expected) begin
            count_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic write_word(input mem_addr_t addr, input data_word_t data,
                              input codeword_t mask);
        wr_en    = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        inj_mask = mask;
        wait_cycle();
        wr_en    = 1'b0;
        inj_mask = '0;
    endtask

    // bypass stays up until the result is back, so the read port samples it
    task automatic read_word(input string name, input mem_addr_t addr, input logic byp,
                             output logic ok);
        int waited;
        waited  = 0;
        ok      = 1'b0;
        rd_en   = 1'b1;
        rd_addr = addr;
        bypass  = byp;
        wait_cycle();
        rd_en = 1'b0;
        while (!ok && waited < 10) begin
            wait_cycle();
            waited++;
            ok = rd_valid;
        end
        bypass = 1'b0;
        if (!ok) begin
            other_errors++;
            $display("timeout: no rd_valid within 10 cycles after the read in %s", name);
        end
    endtask

    task automatic read_burst();
        data_word_t burst_data [0:3];
        int issued;
        int seen;
        int cycles;
        issued = 0;
        seen   = 0;
        cycles = 0;
        for (int i = 0; i < 4; i++) begin
            burst_data[i] = rand_word();
            write_word(mem_addr_t'(56 + i), burst_data[i], '0);
        end
        idle(2);
        // issue one read per cycle while collecting results in order
        while (seen < 4 && cycles < 10) begin
            rd_en   = (issued < 4);
            rd_addr = mem_addr_t'(56 + issued);
            if (issued < 4) begin
                issued++;
            end
            wait_cycle();
            cycles++;
            if (rd_valid) begin
                check_data($sformatf("burst_%0d", seen), burst_data[seen], rd_data);
                check_flag($sformatf("burst_%0d sbit_err", seen), 1'b0, sbit_err);
                check_flag($sformatf("burst_%0d dbit_err", seen), 1'b0, dbit_err);
                seen++;
            end
        end
        rd_en = 1'b0;
        if (seen < 4) begin
            other_errors++;
            $display("timeout: only %0d of 4 back-to-back reads returned", seen);
        end
    endtask

    initial begin
        data_word_t wdata;
        data_word_t exp_data;
        logic       exp_s;
        logic       exp_d;
        logic       ok;
        int         total;
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        inj_mask = '0;
        rd_en    = 1'b0;
        rd_addr  = '0;
        bypass   = 1'b0;
        cnt_clr  = 1'b0;
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        build_columns();
        build_table();
        idle(8);
        rst_n = 1'b1;
        idle(2);

        for (int r = 0; r < row_name.size(); r++) begin
            wdata = rand_word();
            write_word(row_addr[r], wdata, row_mask[r]);
            idle(2);
            model_read(wdata, row_mask[r], row_bypass[r], exp_data, exp_s, exp_d);
            if (exp_s !== row_sbit[r] || exp_d !== row_dbit[r]) begin
                other_errors++;
                $display("model and table disagree on the error class of %s", row_name[r]);
            end
            read_word(row_name[r], row_addr[r], row_bypass[r], ok);
            if (ok) begin
                check_data(row_name[r], exp_data, rd_data);
                check_flag({row_name[r], " sbit_err"}, row_sbit[r], sbit_err);
                check_flag({row_name[r], " dbit_err"}, row_dbit[r], dbit_err);
                if (row_sbit[r]) begin
                    exp_sbit_count = bump_count(exp_sbit_count);
                end
                if (row_dbit[r]) begin
                    exp_dbit_count = bump_count(exp_dbit_count);
                end
                check_count({row_name[r], " sbit_count"}, exp_sbit_count, sbit_count);
                check_count({row_name[r], " dbit_count"}, exp_dbit_count, dbit_count);
            end
        end

        cnt_clr = 1'b1;
        wait_cycle();
        cnt_clr = 1'b0;
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        check_count("cnt_clr sbit_count", exp_sbit_count, sbit_count);
        check_count("cnt_clr dbit_count", exp_dbit_count, dbit_count);

        read_burst();
        idle(2);
        check_count("burst sbit_count", exp_sbit_count, sbit_count);
        check_count("burst dbit_count", exp_dbit_count, dbit_count);

        total = data_errors + flag_errors + count_errors + other_errors
              + dut_i.mem_checker_i.latency_fails + dut_i.mem_checker_i.overlap_fails
              + dut_i.mem_checker_i.stray_fails + dut_i.mem_checker_i.bypass_fails;
        $display("errors: data %0d, flag %0d, count %0d, other %0d, total %0d",
                 data_errors, flag_errors, count_errors, other_errors, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/ecc_mem_pkg.sv
hw/ecc_write_port.sv
hw/ecc_storage.sv
hw/ecc_41_codec.sv
hw/ecc_read_port.sv
hw/ecc_mem_top.sv
testbench/ecc_mem_checker.sv
testbench/tb_ecc_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ecc_mem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)

check: run
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
